//--- project.f
source/DmaPackage.sv
source/AxiChannels.sv
source/BurstReader.sv
source/DataFifo.sv
source/BurstWriter.sv
source/CopyEngine.sv
bench/AxiMemoryModel.sv
bench/CopyEngineBench.sv

//--- bench/CopyEngineBench.sv
module CopyEngineBench;

    logic                   clock;
    logic                   reset;
    logic                   start;
    DmaPackage::Address     sourceAddress;
    DmaPackage::Address     destinationAddress;
    DmaPackage::BurstCount  burstCount;
    logic                   busy;
    logic                   done;
    logic                   readError;
    logic                   writeError;
    DmaPackage::AxiId       awid;
    DmaPackage::AxiId       wid;
    DmaPackage::AxiId       bid;
    DmaPackage::AxiId       arid;
    DmaPackage::AxiId       rid;
    DmaPackage::Address     awaddr;
    DmaPackage::Address     araddr;
    logic [7:0]             awlen;
    logic [7:0]             arlen;
    logic [2:0]             awsize;
    logic [2:0]             arsize;
    logic [1:0]             awburst;
    logic [1:0]             arburst;
    logic [1:0]             awlock;
    logic [1:0]             arlock;
    logic [3:0]             awcache;
    logic [3:0]             arcache;
    logic [2:0]             awprot;
    logic [2:0]             arprot;
    DmaPackage::Word        wdata;
    DmaPackage::Word        rdata;
    logic [3:0]             wstrb;
    DmaPackage::AxiResponse bresp;
    DmaPackage::AxiResponse rresp;
    logic                   awvalid;
    logic                   awready;
    logic                   wlast;
    logic                   wvalid;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;
    logic                   arvalid;
    logic                   arready;
    logic                   rlast;
    logic                   rvalid;
    logic                   rready;

    logic [3:0]             stall;
    DmaPackage::Address     errorReadAddress;
    DmaPackage::Address     errorWriteAddress;
    DmaPackage::Address     noError = 32'hffff_ffc0;
    DmaPackage::Address     expectedAr;
    DmaPackage::Address     expectedAw;
    DmaPackage::Word        lcgState = 32'd43;
    DmaPackage::Word        randomValue;
    logic                   gapsOn;
    int                     wBeats;
    int                     doneCount;
    int                     cycles;
    // bursts over all copies below.
    int                     totalBursts = 16;
    int                     cycleLimit;

    CopyEngine dut_i (.*);

    AxiMemoryModel memory_i (.*);

    function automatic DmaPackage::Word nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic reportFailure(input string message);
        $display("ERROR at time %0t: %s", $time, message);
        $display("Test failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("The run timed out after %0d cycles without finishing.", cycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // gap pattern for awready, wready, arready and rvalid.
    always @(posedge clock) begin
        if (gapsOn) begin
            randomValue = nextRandom();
            stall <= randomValue[31:28];
        end else begin
            stall <= '0;
        end
    end

    // expected addresses and beat count of the running copy.
    always @(posedge clock) begin
        if (reset) begin
            wBeats <= 0;
            doneCount <= 0;
        end else begin
            if (start && !busy) begin
                expectedAr <= sourceAddress;
                expectedAw <= destinationAddress;
                wBeats <= 0;
            end else begin
                if (arvalid && arready) begin
                    expectedAr <= expectedAr + 32'd64;
                end
                if (awvalid && awready) begin
                    expectedAw <= expectedAw + 32'd64;
                end
                if (wvalid && wready) begin
                    wBeats <= wBeats + 1;
                end
            end
            if (done) begin
                doneCount <= doneCount + 1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        arvalid |-> arlen == 8'd15 && arsize == 3'd2 && arburst == 2'd1 && arid == '0
                    && arlock == '0 && arcache == '0 && arprot == '0)
        else reportFailure("AR burst format is wrong");
    assert property (@(posedge clock) disable iff (reset)
        awvalid |-> awlen == 8'd15 && awsize == 3'd2 && awburst == 2'd1 && awid == '0
                    && awlock == '0 && awcache == '0 && awprot == '0)
        else reportFailure("AW burst format is wrong");
    assert property (@(posedge clock) disable iff (reset) arvalid |-> araddr == expectedAr)
        else reportFailure($sformatf("araddr %h, expected %h", araddr, expectedAr));
    assert property (@(posedge clock) disable iff (reset) awvalid |-> awaddr == expectedAw)
        else reportFailure($sformatf("awaddr %h, expected %h", awaddr, expectedAw));
    assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else reportFailure("AR changed before its handshake");
    assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else reportFailure("AW changed before its handshake");
    assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else reportFailure("W beat changed before its handshake");
    assert property (@(posedge clock) disable iff (reset)
        wvalid |-> wstrb == 4'hf && wid == '0)
        else reportFailure($sformatf("wstrb %h wid %h, expected f and 0", wstrb, wid));
    assert property (@(posedge clock) disable iff (reset)
        wvalid && wready |-> wlast == (wBeats % 16 == 15))
        else reportFailure($sformatf("wlast %b on W beat %0d", wlast, wBeats));
    assert property (@(posedge clock) disable iff (reset) done |=> !done)
        else reportFailure("done is longer than one cycle");
    assert property (@(posedge clock) disable iff (reset) done |-> !busy)
        else reportFailure("busy still high with done");
    assert property (@(posedge clock) disable iff (reset) $fell(busy) |-> done)
        else reportFailure("busy fell without done");
    assert property (@(posedge clock) disable iff (reset)
        readError && !(start && !busy) |=> readError)
        else reportFailure("readError cleared without a new start");
    assert property (@(posedge clock) disable iff (reset)
        writeError && !(start && !busy) |=> writeError)
        else reportFailure("writeError cleared without a new start");

    task automatic runCopy(
        input DmaPackage::Address source,
        input DmaPackage::Address destination,
        input int                 bursts,
        input logic               withGaps,
        input logic               retryStart,
        input DmaPackage::Address badRead,
        input DmaPackage::Address badWrite
    );
        DmaPackage::Word expected [$];
        int              i;
        int              doneBefore;
        for (i = 0; i < bursts * 16; i++) begin
            expected.push_back(nextRandom());
            memory_i.memory[source[13:2] + i] = expected[i];
            memory_i.memory[destination[13:2] + i] = 32'h5a5a_0000 ^ (destination + 4 * i);
        end
        errorReadAddress = badRead;
        errorWriteAddress = badWrite;
        gapsOn = withGaps;
        doneBefore = doneCount;
        start = 1'b1;
        sourceAddress = source;
        destinationAddress = destination;
        burstCount = DmaPackage::BurstCount'(bursts);
        @(negedge clock);
        start = 1'b0;
        assert (busy && !readError && !writeError)
            else reportFailure("busy not raised or errors not cleared after start");
        if (retryStart) begin
            repeat (5) @(negedge clock);
            // this start comes while busy.
            start = 1'b1;
            sourceAddress = 32'h0000_1800;
            destinationAddress = 32'h0000_3800;
            burstCount = 16'd2;
            @(negedge clock);
            start = 1'b0;
        end
        while (!done) begin
            @(negedge clock);
        end
        gapsOn = 1'b0;
        assert (wBeats == bursts * 16)
            else reportFailure($sformatf("%0d W beats, expected %0d", wBeats, bursts * 16));
        for (i = 0; i < bursts * 16; i++) begin
            assert (memory_i.memory[destination[13:2] + i] === expected[i])
                else reportFailure($sformatf("destination word %0d is %h, expected %h",
                                             i, memory_i.memory[destination[13:2] + i],
                                             expected[i]));
        end
        assert (readError == (badRead != noError) && writeError == (badWrite != noError))
            else reportFailure($sformatf("readError %b writeError %b", readError, writeError));
        @(negedge clock);
        assert (!done && doneCount == doneBefore + 1)
            else reportFailure("done was not a single pulse for the copy");
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        sourceAddress = '0;
        destinationAddress = '0;
        burstCount = '0;
        stall = '0;
        gapsOn = 1'b0;
        cycles = 0;
        cycleLimit = 200 * totalBursts + 1000;
        errorReadAddress = noError;
        errorWriteAddress = noError;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (!busy && !done && !readError && !writeError && !arvalid && !awvalid && !wvalid
                && rready && bready)
            else reportFailure("outputs are not idle after reset");

        // a zero count starts nothing.
        start = 1'b1;
        burstCount = '0;
        @(negedge clock);
        start = 1'b0;
        repeat (20) @(negedge clock);
        assert (!busy && doneCount == 0 && !arvalid && !awvalid)
            else reportFailure("a burst count of zero started a copy");

        runCopy(32'h0000_0040, 32'h0000_2000, 1, 1'b0, 1'b0, noError, noError);
        runCopy(32'h0000_0400, 32'h0000_2400, 2, 1'b1, 1'b0, 32'h0000_0440, noError);
        runCopy(32'h0000_0800, 32'h0000_2800, 2, 1'b1, 1'b0, noError, 32'h0000_2800);
        runCopy(32'h0000_0c00, 32'h0000_2c00, 3, 1'b0, 1'b0, noError, noError);
        runCopy(32'h0000_1000, 32'h0000_3000, 8, 1'b1, 1'b1, noError, noError);

        repeat (20) @(negedge clock);
        assert (!busy && doneCount == 5)
            else reportFailure($sformatf("%0d done pulses, expected 5", doneCount));
        $display("Test passed");
        $finish;
    end

endmodule

//--- bench/AxiMemoryModel.sv
module AxiMemoryModel (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [3:0]             stall,
    input  DmaPackage::Address     errorReadAddress,
    input  DmaPackage::Address     errorWriteAddress,
    input  DmaPackage::Address     awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  DmaPackage::Word        wdata,
    input  logic                   wlast,
    input  logic                   wvalid,
    output logic                   wready,
    output DmaPackage::AxiId       bid,
    output DmaPackage::AxiResponse bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  DmaPackage::Address     araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output DmaPackage::AxiId       rid,
    output DmaPackage::Word        rdata,
    output DmaPackage::AxiResponse rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready
);

    DmaPackage::Word        memory [4096];
    DmaPackage::Address     readQueue [$];
    DmaPackage::Address     writeQueue [$];
    DmaPackage::AxiResponse responseQueue [$];
    int                     readBeat;
    int                     writeBeat;
    logic                   readPending;
    logic                   responsePending;

    function automatic int wordIndex(input DmaPackage::Address base, input int beat);
        DmaPackage::Address byteAddress;
        byteAddress = base + DmaPackage::Address'(4 * beat);
        return int'(byteAddress[13:2]);
    endfunction

    assign rid = '0;
    assign bid = '0;

    initial begin
        awready = 1'b0;
        wready = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = '0;
        rlast = 1'b0;
        bvalid = 1'b0;
        bresp = '0;
    end

    // handshakes complete on the rising edge.
    always @(posedge clock) begin
        if (reset) begin
            readQueue.delete();
            writeQueue.delete();
            responseQueue.delete();
            readBeat = 0;
            writeBeat = 0;
            readPending = 1'b0;
            responsePending = 1'b0;
        end else begin
            if (arvalid && arready) begin
                readQueue.push_back(araddr);
            end
            if (rvalid && rready) begin
                readPending = 1'b0;
                if (rlast) begin
                    void'(readQueue.pop_front());
                    readBeat = 0;
                end else begin
                    readBeat++;
                end
            end
            if (awvalid && awready) begin
                writeQueue.push_back(awaddr);
            end
            if (wvalid && wready) begin
                memory[wordIndex(writeQueue[0], writeBeat)] = wdata;
                if (wlast) begin
                    // slave error is 2'b10.
                    responseQueue.push_back((writeQueue[0] == errorWriteAddress) ? 2'b10 : 2'b00);
                    void'(writeQueue.pop_front());
                    writeBeat = 0;
                end else begin
                    writeBeat++;
                end
            end
            if (bvalid && bready) begin
                responsePending = 1'b0;
            end
        end
    end

    // outputs change on the falling edge.
    always @(negedge clock) begin
        arready <= !stall[0];
        awready <= !stall[1];
        wready <= !stall[2];
        if (!readPending && readQueue.size() != 0 && !stall[3]) begin
            readPending = 1'b1;
            rdata <= memory[wordIndex(readQueue[0], readBeat)];
            rresp <= (readQueue[0] == errorReadAddress) ? 2'b10 : 2'b00;
            rlast <= (readBeat == 15);
        end
        rvalid <= readPending;
        if (!responsePending && responseQueue.size() != 0) begin
            responsePending = 1'b1;
            bresp <= responseQueue.pop_front();
        end
        bvalid <= responsePending;
    end

endmodule

//--- source/CopyEngine.sv
module CopyEngine (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  DmaPackage::Address     sourceAddress,
    input  DmaPackage::Address     destinationAddress,
    input  DmaPackage::BurstCount  burstCount,
    output logic                   busy,
    output logic                   done,
    output logic                   readError,
    output logic                   writeError,

    output DmaPackage::AxiId       awid,
    output DmaPackage::Address     awaddr,
    output logic [7:0]             awlen,
    output logic [2:0]             awsize,
    output logic [1:0]             awburst,
    output logic [1:0]             awlock,
    output logic [3:0]             awcache,
    output logic [2:0]             awprot,
    output logic                   awvalid,
    input  logic                   awready,

    output DmaPackage::AxiId       wid,
    output DmaPackage::Word        wdata,
    output logic [3:0]             wstrb,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready,

    input  DmaPackage::AxiId       bid,
    input  DmaPackage::AxiResponse bresp,
    input  logic                   bvalid,
    output logic                   bready,

    output DmaPackage::AxiId       arid,
    output DmaPackage::Address     araddr,
    output logic [7:0]             arlen,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,
    output logic [1:0]             arlock,
    output logic [3:0]             arcache,
    output logic [2:0]             arprot,
    output logic                   arvalid,
    input  logic                   arready,

    input  DmaPackage::AxiId       rid,
    input  DmaPackage::Word        rdata,
    input  DmaPackage::AxiResponse rresp,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready
);

    AXIReadAddr  readAddr();
    AXIReadData  readData();
    AXIWriteAddr writeAddr();
    AXIWriteData writeData();
    AXIWriteResp writeResp();
    BurstFifo    fifo();

    logic startAccepted;

    // a start during a copy is dropped.
    assign startAccepted = start && !busy;

    BurstReader reader_i (
        .clock(clock),
        .reset(reset),
        .start(startAccepted),
        .sourceAddress(sourceAddress),
        .burstCount(burstCount),
        .readAddr(readAddr),
        .readData(readData),
        .fifo(fifo),
        .readError(readError)
    );

    DataFifo fifo_i (
        .clock(clock),
        .reset(reset),
        .fifo(fifo)
    );

    BurstWriter writer_i (
        .clock(clock),
        .reset(reset),
        .start(startAccepted),
        .destinationAddress(destinationAddress),
        .burstCount(burstCount),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .writeResp(writeResp),
        .fifo(fifo),
        .busy(busy),
        .done(done),
        .writeError(writeError)
    );

    assign awid = writeAddr.id;
    assign awaddr = writeAddr.address;
    assign awlen = {4'h0, writeAddr.length};
    assign awsize = writeAddr.size;
    assign awburst = writeAddr.burst;
    assign awlock = writeAddr.lock;
    assign awcache = writeAddr.cache;
    assign awprot = writeAddr.protect;
    assign awvalid = writeAddr.valid;
    assign writeAddr.ready = awready;

    // single ID, so W carries ID 0.
    assign wid = '0;
    assign wdata = writeData.data;
    assign wstrb = writeData.strobe;
    assign wlast = writeData.last;
    assign wvalid = writeData.valid;
    assign writeData.ready = wready;

    assign writeResp.id = bid;
    assign writeResp.respond = bresp;
    assign writeResp.valid = bvalid;
    assign bready = writeResp.ready;

    assign arid = readAddr.id;
    assign araddr = readAddr.address;
    assign arlen = {4'h0, readAddr.length};
    assign arsize = readAddr.size;
    assign arburst = readAddr.burst;
    assign arlock = readAddr.lock;
    assign arcache = readAddr.cache;
    assign arprot = readAddr.protect;
    assign arvalid = readAddr.valid;
    assign readAddr.ready = arready;

    assign readData.id = rid;
    assign readData.data = rdata;
    assign readData.respond = rresp;
    assign readData.last = rlast;
    assign readData.valid = rvalid;
    assign rready = readData.ready;

endmodule

//--- source/BurstWriter.sv
module BurstWriter (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  DmaPackage::Address    destinationAddress,
    input  DmaPackage::BurstCount burstCount,
    AXIWriteAddr.master           writeAddr,
    AXIWriteData.master           writeData,
    AXIWriteResp.master           writeResp,
    BurstFifo.consumer            fifo,
    output logic                  busy,
    output logic                  done,
    output logic                  writeError
);

    DmaPackage::WriterState state;
    DmaPackage::Address     address;
    DmaPackage::BurstCount  remaining;
    DmaPackage::BurstCount  total;
    DmaPackage::BurstCount  responses;
    DmaPackage::AxiLength   beat;
    logic                   startAccepted;
    logic                   addressAccepted;
    logic                   beatAccepted;
    logic                   responseAccepted;
    logic                   lastResponse;

    assign startAccepted = start && (burstCount != '0) && (state == DmaPackage::writeIdle);
    assign addressAccepted = writeAddr.valid && writeAddr.ready;
    assign beatAccepted = writeData.valid && writeData.ready;
    assign responseAccepted = writeResp.valid && writeResp.ready;
    assign lastResponse = busy && responseAccepted && (responses == total - 1'b1);

    assign writeAddr.id = '0;
    assign writeAddr.address = address;
    assign writeAddr.length = DmaPackage::AxiLength'(DmaPackage::burstBeats - 1);
    assign writeAddr.size = DmaPackage::sizeWord;
    assign writeAddr.burst = DmaPackage::burstIncr;
    assign writeAddr.lock = '0;
    assign writeAddr.cache = '0;
    assign writeAddr.protect = '0;
    assign writeAddr.valid = (state == DmaPackage::writeAddress);

    // head of the FIFO is the current beat.
    assign writeData.data = fifo.pullData;
    assign writeData.strobe = '1;
    assign writeData.last = (beat == DmaPackage::AxiLength'(DmaPackage::burstBeats - 1));
    assign writeData.valid = (state == DmaPackage::writeData);
    assign writeResp.ready = 1'b1;
    assign fifo.pull = beatAccepted;

    always_ff @(posedge clock) begin
        if (startAccepted) begin
            address <= destinationAddress;
        end else if (addressAccepted) begin
            address <= address + DmaPackage::Address'(DmaPackage::burstBytes);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= DmaPackage::writeIdle;
            remaining <= '0;
            total <= '0;
            responses <= '0;
            beat <= '0;
            busy <= 1'b0;
            done <= 1'b0;
            writeError <= 1'b0;
        end else begin
            done <= lastResponse;
            case (state)
                DmaPackage::writeIdle: begin
                    if (startAccepted) begin
                        total <= burstCount;
                        remaining <= burstCount;
                        responses <= '0;
                        busy <= 1'b1;
                        state <= DmaPackage::writeDrain;
                    end
                end
                DmaPackage::writeAddress: begin
                    if (addressAccepted) begin
                        state <= DmaPackage::writeData;
                    end
                end
                DmaPackage::writeData: begin
                    // beat wraps back to zero after wlast.
                    if (beatAccepted) begin
                        beat <= beat + 1'b1;
                        if (writeData.last) begin
                            remaining <= remaining - 1'b1;
                            state <= DmaPackage::writeDrain;
                        end
                    end
                end
                DmaPackage::writeDrain: begin
                    // wait for a full burst in the buffer.
                    if (remaining != '0
                            && fifo.level >= DmaPackage::FifoLevel'(DmaPackage::burstBeats)) begin
                        state <= DmaPackage::writeAddress;
                    end
                end
                default: state <= DmaPackage::writeIdle;
            endcase
            if (responseAccepted) begin
                responses <= responses + 1'b1;
            end
            // the last B always follows the last W beat.
            if (lastResponse) begin
                busy <= 1'b0;
                state <= DmaPackage::writeIdle;
            end
            if (startAccepted) begin
                writeError <= 1'b0;
            end else if (responseAccepted && writeResp.respond != DmaPackage::respOkay) begin
                writeError <= 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        writeData.valid && !writeData.ready |=> writeData.valid && $stable(writeData.data));

    // wlast lands on the sixteenth accepted beat after each AW.
    assert property (@(posedge clock) disable iff (reset)
        addressAccepted |=> beatAccepted [-> DmaPackage::burstBeats] ##0 writeData.last);

endmodule

//--- source/DataFifo.sv
module DataFifo (
    input logic      clock,
    input logic      reset,
    BurstFifo.buffer fifo
);

    DmaPackage::Word                         memory [DmaPackage::fifoDepth];
    logic [DmaPackage::fifoAddressWidth-1:0] readPointer;
    logic [DmaPackage::fifoAddressWidth-1:0] writePointer;
    DmaPackage::FifoLevel                    count;

    always_ff @(posedge clock) begin
        if (fifo.push) begin
            memory[writePointer] <= fifo.pushData;
        end
    end

    // pointers wrap at the depth.
    always_ff @(posedge clock) begin
        if (reset) begin
            readPointer <= '0;
            writePointer <= '0;
            count <= '0;
        end else begin
            if (fifo.push) begin
                writePointer <= writePointer + 1'b1;
            end
            if (fifo.pull) begin
                readPointer <= readPointer + 1'b1;
            end
            count <= count + DmaPackage::FifoLevel'(fifo.push)
                     - DmaPackage::FifoLevel'(fifo.pull);
        end
    end

    assign fifo.pullData = memory[readPointer];
    assign fifo.level = count;

    assert property (@(posedge clock) disable iff (reset)
        fifo.pull |-> count != '0);

    assert property (@(posedge clock) disable iff (reset)
        fifo.push |-> count != DmaPackage::FifoLevel'(DmaPackage::fifoDepth));

endmodule

//--- source/BurstReader.sv
module BurstReader (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  DmaPackage::Address    sourceAddress,
    input  DmaPackage::BurstCount burstCount,
    AXIReadAddr.master            readAddr,
    AXIReadData.master            readData,
    BurstFifo.producer            fifo,
    output logic                  readError
);

    DmaPackage::ReaderState state;
    DmaPackage::Address     address;
    DmaPackage::BurstCount  remaining;
    DmaPackage::FifoLevel   reserved;
    logic                   startAccepted;
    logic                   addressAccepted;
    logic                   beatAccepted;
    logic                   hasRoom;

    assign startAccepted = start && (burstCount != '0);
    assign addressAccepted = readAddr.valid && readAddr.ready;
    assign beatAccepted = readData.valid && readData.ready;

    // buffered plus in-flight words must leave space for a whole burst.
    assign hasRoom = (7'(fifo.level) + 7'(reserved))
                     <= 7'(DmaPackage::fifoDepth - DmaPackage::burstBeats);

    assign readAddr.id = '0;
    assign readAddr.address = address;
    assign readAddr.length = DmaPackage::AxiLength'(DmaPackage::burstBeats - 1);
    assign readAddr.size = DmaPackage::sizeWord;
    assign readAddr.burst = DmaPackage::burstIncr;
    assign readAddr.lock = '0;
    assign readAddr.cache = '0;
    assign readAddr.protect = '0;
    assign readAddr.valid = (state == DmaPackage::readAddress);

    // space is claimed before the AR goes out.
    assign readData.ready = 1'b1;
    assign fifo.push = beatAccepted;
    assign fifo.pushData = readData.data;

    always_ff @(posedge clock) begin
        if (startAccepted && state == DmaPackage::readIdle) begin
            address <= sourceAddress;
        end else if (addressAccepted) begin
            address <= address + DmaPackage::Address'(DmaPackage::burstBytes);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= DmaPackage::readIdle;
            remaining <= '0;
            reserved <= '0;
            readError <= 1'b0;
        end else begin
            reserved <= reserved
                        + (addressAccepted ? DmaPackage::FifoLevel'(DmaPackage::burstBeats) : '0)
                        - DmaPackage::FifoLevel'(beatAccepted);
            case (state)
                DmaPackage::readIdle: begin
                    if (startAccepted) begin
                        remaining <= burstCount;
                        state <= DmaPackage::readAddress;
                    end
                end
                DmaPackage::readAddress: begin
                    if (addressAccepted) begin
                        remaining <= remaining - 1'b1;
                        // data of the last bursts still drains after this.
                        state <= (remaining == 1) ? DmaPackage::readIdle : DmaPackage::readWait;
                    end
                end
                DmaPackage::readWait: begin
                    if (hasRoom) begin
                        state <= DmaPackage::readAddress;
                    end
                end
                default: state <= DmaPackage::readIdle;
            endcase
            if (startAccepted && state == DmaPackage::readIdle) begin
                readError <= 1'b0;
            end else if (beatAccepted && readData.respond != DmaPackage::respOkay) begin
                readError <= 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        readAddr.valid && !readAddr.ready |=> readAddr.valid && $stable(readAddr.address));

    // every returned beat lands in space claimed by an earlier AR.
    assert property (@(posedge clock) disable iff (reset)
        fifo.push |-> reserved != '0);

endmodule

//--- source/AxiChannels.sv
interface AXIReadAddr;
    DmaPackage::AxiId     id;
    DmaPackage::Address   address;
    DmaPackage::AxiLength length;
    logic [2:0]           size;
    logic [1:0]           burst;
    logic [1:0]           lock;
    logic [3:0]           cache;
    logic [2:0]           protect;
    logic                 valid;
    logic                 ready;

    modport master(output id, address, length, size, burst, lock, cache, protect, valid,
                   input ready);
    modport slave(input id, address, length, size, burst, lock, cache, protect, valid,
                  output ready);
endinterface

interface AXIReadData;
    DmaPackage::AxiId       id;
    DmaPackage::Word        data;
    DmaPackage::AxiResponse respond;
    logic                   last;
    logic                   valid;
    logic                   ready;

    modport master(input id, data, respond, last, valid, output ready);
    modport slave(output id, data, respond, last, valid, input ready);
endinterface

interface AXIWriteAddr;
    DmaPackage::AxiId     id;
    DmaPackage::Address   address;
    DmaPackage::AxiLength length;
    logic [2:0]           size;
    logic [1:0]           burst;
    logic [1:0]           lock;
    logic [3:0]           cache;
    logic [2:0]           protect;
    logic                 valid;
    logic                 ready;

    modport master(output id, address, length, size, burst, lock, cache, protect, valid,
                   input ready);
    modport slave(input id, address, length, size, burst, lock, cache, protect, valid,
                  output ready);
endinterface

interface AXIWriteData;
    DmaPackage::Word data;
    logic [3:0]      strobe;
    logic            last;
    logic            valid;
    logic            ready;

    modport master(output data, strobe, last, valid, input ready);
    modport slave(input data, strobe, last, valid, output ready);
endinterface

interface AXIWriteResp;
    DmaPackage::AxiId       id;
    DmaPackage::AxiResponse respond;
    logic                   valid;
    logic                   ready;

    modport master(input id, respond, valid, output ready);
    modport slave(output id, respond, valid, input ready);
endinterface

// buffer between the read and write sides.
interface BurstFifo;
    logic                 push;
    DmaPackage::Word      pushData;
    logic                 pull;
    DmaPackage::Word      pullData;
    DmaPackage::FifoLevel level;

    modport producer(output push, pushData, input level);
    modport consumer(output pull, input pullData, level);
    modport buffer(input push, pushData, pull, output pullData, level);
endinterface

//--- source/DmaPackage.sv
package DmaPackage;

    typedef logic [31:0] Address;
    typedef logic [31:0] Word;
    typedef logic [15:0] BurstCount;
    typedef logic [3:0]  AxiId;
    typedef logic [3:0]  AxiLength;
    typedef logic [1:0]  AxiResponse;
    typedef logic [5:0]  FifoLevel;

    // one burst is sixteen 32-bit beats.
    localparam int burstBeats = 16;
    localparam int fifoDepth = 32;
    localparam int fifoAddressWidth = $clog2(fifoDepth);
    localparam int burstBytes = 64;

    localparam AxiResponse respOkay = 2'd0;
    localparam logic [1:0] burstIncr = 2'd1;
    localparam logic [2:0] sizeWord = 3'd2;

    typedef enum logic [1:0] {
        readIdle,
        readAddress,
        readWait
    } ReaderState;

    typedef enum logic [1:0] {
        writeIdle,
        writeAddress,
        writeData,
        writeDrain
    } WriterState;

endpackage
